// ==== bench/axi_router_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axi_router_cfg.svh"

module axi_router_checker #(
    parameter int NTR = 12
) (
    input  wire logic                                           clk,
    input  wire logic                                           rst_n,
    input  wire logic [`AXR_OUTPUTS-1:0]                        out_aw_valid,
    input  wire logic [`AXR_OUTPUTS-1:0]                        out_aw_ready,
    input  wire axi_router_pkg::aw_cmd_t [`AXR_OUTPUTS-1:0]     out_aw,
    input  wire logic [`AXR_OUTPUTS-1:0]                        out_w_valid,
    input  wire logic [`AXR_OUTPUTS-1:0]                        out_w_ready,
    input  wire logic [`AXR_OUTPUTS-1:0]                        out_w_last,
    input  wire axi_router_pkg::w_beat_t [`AXR_OUTPUTS-1:0]     out_w,
    input  wire logic [`AXR_INPUTS-1:0]                         in_b_valid,
    input  wire logic [`AXR_INPUTS-1:0]                         in_b_ready,
    input  wire axi_router_pkg::b_resp_t [`AXR_INPUTS-1:0]      in_b,
    output int                                                  errors,
    output int                                                  done
);
    import axi_router_pkg::*;

    logic [31:0] gold [NTR*5];      // input, addr, len, data, resp per transaction
    int exp_out [`AXR_OUTPUTS][$];  // transactions in arrival order per output
    int exp_in [`AXR_INPUTS][$];
    int nxt [`AXR_INPUTS];          // next command each input still owes
    int beat [`AXR_OUTPUTS];
    logic was_rst;                  // reset seen at the previous edge

    function automatic int next_of(int i, int from);
        for (int t = from; t < NTR; t++) begin
            if (gold[5*t] == 32'(i)) return t;
        end
        return NTR;
    endfunction

    initial begin
        errors = 0;
        done = 0;
        was_rst = 1'b0;
        $readmemh("bench/axi_router_golden.txt", gold);
        for (int i = 0; i < `AXR_INPUTS; i++) nxt[i] = next_of(i, 0);
        for (int o = 0; o < `AXR_OUTPUTS; o++) beat[o] = 0;
    end

    always @(posedge clk) begin : watch
        int t;
        int src;
        // valids must be clean from the edge after reset is first applied
        if (was_rst && (out_aw_valid !== '0 || out_w_valid !== '0 || in_b_valid !== '0)) begin
            $display("error at %0t: a valid output is not low during or just after reset",
                     $time);
            errors++;
        end
        was_rst = !rst_n;
        if (rst_n) begin
            for (int o = 0; o < `AXR_OUTPUTS; o++) begin
                if (out_aw_valid[o] && out_aw_ready[o]) begin
                    src = -1;
                    for (int i = 0; i < `AXR_INPUTS; i++) begin
                        if (nxt[i] < NTR && gold[5*nxt[i]+1] == out_aw[o].addr) src = i;
                    end
                    if (src < 0) begin
                        $display("error at %0t: output %0d got a command out of order, addr %h",
                                 $time, o, out_aw[o].addr);
                        errors++;
                    end else begin
                        t = nxt[src];
                        if (out_aw[o].len != gold[5*t+2][`AXR_LEN-1:0]) begin
                            $display("mismatch at %0t: out_aw[%0d].len got %h expected %h",
                                     $time, o, out_aw[o].len, gold[5*t+2][`AXR_LEN-1:0]);
                            errors++;
                        end
                        if (int'(gold[5*t+1][31]) != o) begin   // top bit picks the output
                            $display("mismatch at %0t: out_aw_valid output got %0d expected %0d",
                                     $time, o, gold[5*t+1][31]);
                            errors++;
                        end
                        exp_out[o].push_back(t);
                        exp_in[src].push_back(t);
                        nxt[src] = next_of(src, t + 1);
                    end
                end
                if (out_w_valid[o] && out_w_ready[o]) begin
                    if (exp_out[o].size() == 0) begin
                        $display("error at %0t: beat on output %0d with no command", $time, o);
                        errors++;
                    end else begin
                        t = exp_out[o][0];
                        if (out_w[o].data != gold[5*t+3] + 32'(beat[o]) ||
                            out_w[o].strb != 4'hf) begin
                            $display("mismatch at %0t: out_w[%0d] got %h expected %h", $time, o,
                                     out_w[o], {4'hf, gold[5*t+3] + 32'(beat[o])});
                            errors++;
                        end
                        if (out_w_last[o] != (beat[o] == int'(gold[5*t+2]))) begin
                            $display("mismatch at %0t: out_w_last[%0d] got %b expected %b",
                                     $time, o, out_w_last[o], beat[o] == int'(gold[5*t+2]));
                            errors++;
                        end
                        beat[o]++;
                        if (beat[o] > int'(gold[5*t+2])) begin
                            beat[o] = 0;
                            void'(exp_out[o].pop_front());
                        end
                    end
                end
            end
            for (int i = 0; i < `AXR_INPUTS; i++) begin
                if (in_b_valid[i] && in_b_ready[i]) begin
                    if (exp_in[i].size() == 0) begin
                        $display("error at %0t: response on input %0d with no command", $time, i);
                        errors++;
                    end else begin
                        t = exp_in[i].pop_front();
                        if (in_b[i].code != gold[5*t+4][1:0]) begin
                            $display("mismatch at %0t: in_b[%0d] got %h expected %h",
                                     $time, i, in_b[i].code, gold[5*t+4][1:0]);
                            errors++;
                        end
                        $display("transaction %0d, input %0d, addr %h done", t, i, gold[5*t+1]);
                        done++;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== bench/axi_router_golden.txt ====
// columns: input, address, length (beats minus one), first data word, response code
// one transaction per line, all values hex
0 00000100 3 a0000000 0
1 80000200 1 b1000000 1
0 80000300 0 a2000000 2
1 00000400 2 b3000000 0
0 00000500 1 a4000000 3
1 80000600 3 b5000000 2
0 80000700 2 a6000000 0
1 00000800 0 b7000000 1
0 00000900 3 a8000000 2
1 80000a00 1 b9000000 0
0 80000b00 0 aa000000 1
1 00000c00 2 bb000000 3

// ==== bench/tb_axi_router_wr.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axi_router_cfg.svh"

module tb_axi_router_wr;
    import axi_router_pkg::*;

    localparam int NTR = 12;

    logic clk;
    logic rst_n;
    logic [`AXR_INPUTS-1:0]             in_aw_valid, in_aw_ready, in_w_valid, in_w_ready;
    logic [`AXR_INPUTS-1:0]             in_w_last, in_b_valid, in_b_ready;
    aw_cmd_t [`AXR_INPUTS-1:0]          in_aw;
    w_beat_t [`AXR_INPUTS-1:0]          in_w;
    b_resp_t [`AXR_INPUTS-1:0]          in_b;
    logic [`AXR_OUTPUTS-1:0]            out_aw_valid, out_aw_ready, out_w_valid, out_w_ready;
    logic [`AXR_OUTPUTS-1:0]            out_w_last, out_b_valid, out_b_ready;
    aw_cmd_t [`AXR_OUTPUTS-1:0]         out_aw;
    w_beat_t [`AXR_OUTPUTS-1:0]         out_w;
    b_resp_t [`AXR_OUTPUTS-1:0]         out_b;

    logic [31:0] gold [NTR*5];
    logic [31:0] lcg;
    b_resp_t     pend [`AXR_OUTPUTS][$];    // responses owed per slave
    int          done_w [`AXR_OUTPUTS];
    int          errors, done, cycles, limit;

    axi_router_wr dut0 (.*);

    axi_router_checker #(.NTR(NTR)) checker0 (.*);

    function automatic logic rnd();
        lcg = lcg * 32'd1103515245 + 32'd12345;
        return lcg[16] | lcg[21];   // high about three times in four
    endfunction

    function automatic b_resp_t resp_for(logic [31:0] addr);
        for (int t = 0; t < NTR; t++) begin
            if (gold[5*t+1] == addr) return b_resp_t'(gold[5*t+4][1:0]);
        end
        return '0;
    endfunction

    task automatic send_commands(int i);
        @(posedge clk);
        for (int t = 0; t < NTR; t++) begin
            if (gold[5*t] == 32'(i)) begin
                if (!rnd()) begin
                    in_aw_valid[i] <= 1'b0;
                    @(posedge clk);
                end
                in_aw_valid[i] <= 1'b1;
                in_aw[i] <= aw_cmd_t'{gold[5*t+1], gold[5*t+2][`AXR_LEN-1:0]};
                do @(posedge clk); while (!in_aw_ready[i]);
            end
        end
        in_aw_valid[i] <= 1'b0;
    endtask

    task automatic send_beats(int i);
        @(posedge clk);
        for (int t = 0; t < NTR; t++) begin
            for (int k = 0; gold[5*t] == 32'(i) && k <= int'(gold[5*t+2]); k++) begin
                if (!rnd()) begin
                    in_w_valid[i] <= 1'b0;
                    @(posedge clk);
                end
                in_w_valid[i] <= 1'b1;
                in_w[i] <= w_beat_t'{4'hf, gold[5*t+3] + 32'(k)};
                in_w_last[i] <= (k == int'(gold[5*t+2]));
                do @(posedge clk); while (!in_w_ready[i]);
            end
        end
        in_w_valid[i] <= 1'b0;
    endtask

    task automatic accept_slave(int o);
        forever begin
            @(posedge clk);
            if (out_aw_valid[o] && out_aw_ready[o]) pend[o].push_back(resp_for(out_aw[o].addr));
            if (out_w_valid[o] && out_w_ready[o] && out_w_last[o]) done_w[o]++;
            out_aw_ready[o] <= rnd();
            out_w_ready[o] <= rnd();
        end
    endtask

    task automatic respond_slave(int o);
        int sent;
        sent = 0;
        forever begin
            @(posedge clk);
            if (done_w[o] > sent && pend[o].size() > 0) begin
                out_b_valid[o] <= 1'b1;
                out_b[o] <= pend[o].pop_front();
                do @(posedge clk); while (!out_b_ready[o]);
                out_b_valid[o] <= 1'b0;
                sent++;
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        lcg = 32'h1bf3;
        done_w = '{0, 0};
        $readmemh("bench/axi_router_golden.txt", gold);
        rst_n <= 1'b0;
        in_aw_valid <= '0;
        in_aw <= '0;
        in_w_valid <= '0;
        in_w_last <= '0;
        in_w <= '0;
        in_b_ready <= '0;
        out_aw_ready <= '0;
        out_w_ready <= '0;
        out_b_valid <= '0;
        out_b <= '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        fork
            send_commands(0);
            send_commands(1);
            send_beats(0);
            send_beats(1);
            accept_slave(0);
            accept_slave(1);
            respond_slave(0);
            respond_slave(1);
            forever begin
                @(posedge clk);
                in_b_ready <= {rnd(), rnd()};
            end
        join_none
    end

    initial begin
        cycles = 0;
        limit = 64 * NTR;
        #1;
        for (int t = 0; t < NTR; t++) limit += int'(gold[5*t+2]) + 1;
        while (done < NTR && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        repeat (2) @(posedge clk);
        if (cycles >= limit && done < NTR) begin
            $display("timeout: only %0d of %0d transactions finished in %0d cycles",
                     done, NTR, limit);
        end
        $display("%0d transactions done, %0d errors", done, errors);
        if (errors == 0 && done == NTR) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the router testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -j 0 --top-module tb_axi_router_wr -f tb.f -o sim_tb
out=$(./obj_dir/sim_tb)
echo "$out"
echo "$out" | grep -q "All tests passed!"

// ==== tb.f ====
+incdir+verilog
verilog/axi_router_pkg.sv
verilog/axi_route_queue.sv
verilog/axi_router_command.sv
verilog/axi_router_channel.sv
verilog/axi_router_wr.sv
bench/axi_router_checker.sv
bench/tb_axi_router_wr.sv

// ==== verilog/axi_route_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axi_router_cfg.svh"

module axi_route_queue (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    push,
    input  axi_router_pkg::route_t  push_route,
    input  logic                    pop,
    output axi_router_pkg::route_t  head,
    output logic                    empty,
    output logic                    full
);
    import axi_router_pkg::*;

    localparam int DEPTH = `AXR_MOT;
    localparam int PTR_W = $clog2(DEPTH);

    route_t             mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W:0]     count;
    logic               do_push;
    logic               do_pop;

    assign full    = (count == (PTR_W+1)'(DEPTH));
    assign empty   = (count == '0);
    assign do_push = push && !full;     // dropped when full
    assign do_pop  = pop && !empty;
    assign head    = mem[rd_ptr];       // unregistered head

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= push_route;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            if (do_push && !do_pop) count <= count + 1'b1;
            else if (do_pop && !do_push) count <= count - 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/axi_router_cfg.svh ====
`ifndef AXI_ROUTER_CFG_SVH
`define AXI_ROUTER_CFG_SVH

// bus widths
`define AXR_ADDR    32
`define AXR_DATA    32
`define AXR_LEN     4

// port counts
`define AXR_INPUTS  2              // masters
`define AXR_OUTPUTS 2              // slaves

`define AXR_MOT     8              // route queue depth per channel

// a hit on an output window is (addr & mask) == base
`define AXR_BASE0   32'h0000_0000
`define AXR_MASK0   32'h8000_0000
`define AXR_BASE1   32'h8000_0000
`define AXR_MASK1   32'h8000_0000

`endif

// ==== verilog/axi_router_channel.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axi_router_cfg.svh"

module axi_router_channel #(
    parameter type payload_t = axi_router_pkg::w_beat_t,
    parameter int  SOURCES   = `AXR_INPUTS,
    parameter int  SINKS     = `AXR_OUTPUTS
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    cmd_push,
    input  axi_router_pkg::route_t  cmd_route,
    output logic                    route_full,
    input  logic [SOURCES-1:0]      source_valid,
    output logic [SOURCES-1:0]      source_ready,
    input  logic [SOURCES-1:0]      source_last,
    input  payload_t [SOURCES-1:0]  source,
    output logic [SINKS-1:0]        sink_valid,
    input  logic [SINKS-1:0]        sink_ready,
    output logic [SINKS-1:0]        sink_last,
    output payload_t [SINKS-1:0]    sink
);
    import axi_router_pkg::*;

    route_t     head;
    logic       empty;
    logic       beat_valid;
    logic       beat_last;
    logic       beat_fire;
    payload_t   beat;

    axi_route_queue route_queue0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (cmd_push),
        .push_route (cmd_route),
        .pop        (beat_fire && beat_last),   // route retires on last beat
        .head       (head),
        .empty      (empty),
        .full       (route_full)
    );

    // selected source as seen through the head route
    assign beat_valid = !empty && source_valid[head.src];
    assign beat_last  = source_last[head.src];
    assign beat       = source[head.src];
    assign beat_fire  = beat_valid && sink_ready[head.snk];

    always_comb begin
        for (int s = 0; s < SOURCES; s++) begin
            // sink back-pressure straight through
            source_ready[s] = !empty && (head.src == IDX_W'(s)) && sink_ready[head.snk];
        end
        for (int k = 0; k < SINKS; k++) begin
            sink_valid[k] = beat_valid && (head.snk == IDX_W'(k));
            sink_last[k]  = sink_valid[k] && beat_last;
            sink[k]       = (head.snk == IDX_W'(k)) ? beat : '0;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/axi_router_command.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axi_router_cfg.svh"

module axi_router_command (
    input  logic                                            clk,
    input  logic                                            rst_n,
    input  logic [`AXR_INPUTS-1:0]                          in_aw_valid,
    output logic [`AXR_INPUTS-1:0]                          in_aw_ready,
    input  axi_router_pkg::aw_cmd_t [`AXR_INPUTS-1:0]       in_aw,
    output logic [`AXR_OUTPUTS-1:0]                         out_aw_valid,
    input  logic [`AXR_OUTPUTS-1:0]                         out_aw_ready,
    output axi_router_pkg::aw_cmd_t [`AXR_OUTPUTS-1:0]      out_aw,
    input  logic                                            route_full,
    output logic                                            cmd_push,
    output axi_router_pkg::route_t                          cmd_route
);
    import axi_router_pkg::*;

    localparam int INPUTS  = `AXR_INPUTS;
    localparam int OUTPUTS = `AXR_OUTPUTS;

    localparam logic [`AXR_ADDR-1:0] BASES [OUTPUTS] = '{`AXR_BASE0, `AXR_BASE1};
    localparam logic [`AXR_ADDR-1:0] MASKS [OUTPUTS] = '{`AXR_MASK0, `AXR_MASK1};

    logic               busy;           // command register occupied
    aw_cmd_t            cmd_q;
    route_t             route_q;
    logic [IDX_W-1:0]   rr_ptr;         // first input to look at
    logic               grant_found;
    logic [IDX_W-1:0]   grant_idx;
    logic [IDX_W-1:0]   dec_sink;
    logic               accept;
    logic               out_fire;

    // round robin picks the nearest valid input at or after the pointer
    always_comb begin
        int unsigned idx;
        grant_found = 1'b0;
        grant_idx   = '0;
        for (int k = INPUTS - 1; k >= 0; k--) begin
            idx = (int'(rr_ptr) + k) % INPUTS;
            if (in_aw_valid[idx]) begin
                grant_found = 1'b1;
                grant_idx   = IDX_W'(idx);
            end
        end
    end

    // lowest matching window wins and a miss goes to the last output
    always_comb begin
        dec_sink = IDX_W'(OUTPUTS - 1);
        for (int o = OUTPUTS - 1; o >= 0; o--) begin
            if ((in_aw[grant_idx].addr & MASKS[o]) == BASES[o]) dec_sink = IDX_W'(o);
        end
    end

    assign accept   = !busy && !route_full && grant_found;
    assign out_fire = busy && out_aw_ready[route_q.snk];

    always_comb begin
        for (int i = 0; i < INPUTS; i++) begin
            in_aw_ready[i] = accept && (grant_idx == IDX_W'(i));
        end
        for (int o = 0; o < OUTPUTS; o++) begin
            out_aw_valid[o] = busy && (route_q.snk == IDX_W'(o));
            out_aw[o]       = out_aw_valid[o] ? cmd_q : '0;    // idle outputs stay quiet
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy   <= 1'b0;
            rr_ptr <= '0;
        end else if (accept) begin
            busy   <= 1'b1;
            rr_ptr <= IDX_W'((int'(grant_idx) + 1) % INPUTS);  // skip past granted input
        end else if (out_fire) begin
            busy   <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_q       <= in_aw[grant_idx];
            route_q.src <= grant_idx;
            route_q.snk <= dec_sink;
        end
    end

    // route goes into the queues as the command leaves
    assign cmd_push  = out_fire;
    assign cmd_route = route_q;

endmodule

`default_nettype wire

// ==== verilog/axi_router_pkg.sv ====
`default_nettype none

package axi_router_pkg;

`include "axi_router_cfg.svh"

    // index width wide enough for either direction of a route
    localparam int IN_W  = (`AXR_INPUTS  > 1) ? $clog2(`AXR_INPUTS)  : 1;
    localparam int OUT_W = (`AXR_OUTPUTS > 1) ? $clog2(`AXR_OUTPUTS) : 1;
    localparam int IDX_W = (IN_W > OUT_W) ? IN_W : OUT_W;

    typedef struct packed {
        logic [`AXR_ADDR-1:0]   addr;
        logic [`AXR_LEN-1:0]    len;    // beats minus one
    } aw_cmd_t;

    typedef struct packed {
        logic [`AXR_DATA/8-1:0] strb;
        logic [`AXR_DATA-1:0]   data;
    } w_beat_t;

    typedef struct packed {
        logic [1:0] code;               // okay / exokay / slverr / decerr
    } b_resp_t;

    typedef struct packed {
        logic [IDX_W-1:0] src;
        logic [IDX_W-1:0] snk;
    } route_t;

endpackage

`default_nettype wire

// ==== verilog/axi_router_wr.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axi_router_cfg.svh"

module axi_router_wr (
    input  logic                                        clk,
    input  logic                                        rst_n,

    // masters
    input  logic [`AXR_INPUTS-1:0]                      in_aw_valid,
    output logic [`AXR_INPUTS-1:0]                      in_aw_ready,
    input  axi_router_pkg::aw_cmd_t [`AXR_INPUTS-1:0]   in_aw,
    input  logic [`AXR_INPUTS-1:0]                      in_w_valid,
    output logic [`AXR_INPUTS-1:0]                      in_w_ready,
    input  logic [`AXR_INPUTS-1:0]                      in_w_last,
    input  axi_router_pkg::w_beat_t [`AXR_INPUTS-1:0]   in_w,
    output logic [`AXR_INPUTS-1:0]                      in_b_valid,
    input  logic [`AXR_INPUTS-1:0]                      in_b_ready,
    output axi_router_pkg::b_resp_t [`AXR_INPUTS-1:0]   in_b,

    // slaves
    output logic [`AXR_OUTPUTS-1:0]                     out_aw_valid,
    input  logic [`AXR_OUTPUTS-1:0]                     out_aw_ready,
    output axi_router_pkg::aw_cmd_t [`AXR_OUTPUTS-1:0]  out_aw,
    output logic [`AXR_OUTPUTS-1:0]                     out_w_valid,
    input  logic [`AXR_OUTPUTS-1:0]                     out_w_ready,
    output logic [`AXR_OUTPUTS-1:0]                     out_w_last,
    output axi_router_pkg::w_beat_t [`AXR_OUTPUTS-1:0]  out_w,
    input  logic [`AXR_OUTPUTS-1:0]                     out_b_valid,
    output logic [`AXR_OUTPUTS-1:0]                     out_b_ready,
    input  axi_router_pkg::b_resp_t [`AXR_OUTPUTS-1:0]  out_b
);
    import axi_router_pkg::*;

    logic       cmd_push;
    route_t     cmd_route;
    route_t     b_route;        // output back to input
    logic       w_full;
    logic       b_full;
    logic       route_full;

    assign route_full  = w_full | b_full;
    assign b_route.src = cmd_route.snk;
    assign b_route.snk = cmd_route.src;

    axi_router_command command0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_aw_valid  (in_aw_valid),
        .in_aw_ready  (in_aw_ready),
        .in_aw        (in_aw),
        .out_aw_valid (out_aw_valid),
        .out_aw_ready (out_aw_ready),
        .out_aw       (out_aw),
        .route_full   (route_full),
        .cmd_push     (cmd_push),
        .cmd_route    (cmd_route)
    );

    axi_router_channel #(
        .payload_t (w_beat_t),
        .SOURCES   (`AXR_INPUTS),
        .SINKS     (`AXR_OUTPUTS)
    ) channel_w (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_push     (cmd_push),
        .cmd_route    (cmd_route),
        .route_full   (w_full),
        .source_valid (in_w_valid),
        .source_ready (in_w_ready),
        .source_last  (in_w_last),
        .source       (in_w),
        .sink_valid   (out_w_valid),
        .sink_ready   (out_w_ready),
        .sink_last    (out_w_last),
        .sink         (out_w)
    );

    // one beat per response, so last is always set
    axi_router_channel #(
        .payload_t (b_resp_t),
        .SOURCES   (`AXR_OUTPUTS),
        .SINKS     (`AXR_INPUTS)
    ) channel_b (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_push     (cmd_push),
        .cmd_route    (b_route),
        .route_full   (b_full),
        .source_valid (out_b_valid),
        .source_ready (out_b_ready),
        .source_last  ({`AXR_OUTPUTS{1'b1}}),
        .source       (out_b),
        .sink_valid   (in_b_valid),
        .sink_ready   (in_b_ready),
        .sink_last    (),
        .sink         (in_b)
    );

endmodule

`default_nettype wire
